/* common/ks10Pkg.sv */
// Shared constants for the KS-10 backplane memory controller.
// Bus words are numbered 0 to 35 from the MSB, as on the backplane.
// Modules import this package inside their bodies and use scoped
// names in their port lists.

package ks10Pkg;

   //////////////////////////////
   // Bus word
   //////////////////////////////

   localparam int busWidth   = 36;        // Address and data word

   // Request flags in the address word
   localparam int flagRead   = 3;         // Read cycle
   localparam int flagWrTest = 4;         // Write-test cycle
   localparam int flagWrite  = 5;         // Write cycle
   localparam int flagPhys   = 8;         // Physical reference
   localparam int flagIo     = 10;        // I/O cycle

   // Device number field, bits 14 to 17
   localparam int devLo      = 14;
   localparam int devHi      = 17;

   localparam int ioAddrLo   = 18;        // 18-bit I/O address up to bit 35
   localparam int memAddrLo  = 16;        // 20-bit memory address up to bit 35

   //////////////////////////////
   // Controller identity
   //////////////////////////////

   localparam int memDev     = 0;         // Memory controller device number
   localparam int addrMsr    = 'o100000;  // Status register I/O address

   //////////////////////////////
   // Memory status register
   //////////////////////////////

   localparam int msrNxm     = 0;         // Sticky nonexistent memory

   // Stored control field, 8 bits
   localparam int msrCtlLo   = 28;
   localparam int msrCtlHi   = 35;

endpackage

/* filelist.f */
common/ks10Pkg.sv
mem/busDecode.sv
mem/memStat.sv
mem/memSeq.sv
mem/ssramArray.sv
mem/mem.sv
tb/memTb.sv

/* mem/busDecode.sv */
// Request side of the memory controller.
// Samples the one-cycle bus strobe, splits the address word and
// classifies the cycle as memory, status register or ignored.
// Start pulse and decoded values appear the cycle after the strobe.

`timescale 1ns/1ns

module busDecode #(
      parameter int ramAddrWidth = 10                            // RAM address bits
   ) (
      input  logic                          cpuClk,              // CPU clock
      input  logic                          rst,                 // Sync reset
      input  logic                          busReq,              // Request strobe
      input  logic [0:ks10Pkg::busWidth-1]  busAddrIn,           // Flags and address
      input  logic [0:ks10Pkg::busWidth-1]  busDataIn,           // Write data
      output logic                          memGo,               // Start access
      output logic                          isWrite,             // Write cycle
      output logic                          isMsr,               // Status register cycle
      output logic                          msrWr,               // Status register write
      output logic                          nxmSet,              // Nonexistent memory hit
      output logic [ramAddrWidth-1:0]       ramAddr,             // Latched RAM address
      output logic [0:ks10Pkg::busWidth-1]  dataLatch            // Latched data word
   );

   import ks10Pkg::*;

   localparam int memAddrWidth = busWidth - memAddrLo;

   // Address word fields
   wire                    reqRead    = busAddrIn[flagRead];
   wire                    reqWrTest  = busAddrIn[flagWrTest];
   wire                    reqWrite   = busAddrIn[flagWrite];
   wire                    reqPhys    = busAddrIn[flagPhys];
   wire                    reqIo      = busAddrIn[flagIo];
   wire [0:3]              reqDev     = busAddrIn[devLo:devHi];
   wire [0:17]             reqIoAddr  = busAddrIn[ioAddrLo:busWidth-1];
   wire [0:memAddrWidth-1] reqMemAddr = busAddrIn[memAddrLo:busWidth-1];

   logic [2:0] busyCnt;                                          // Cycles left in access
   wire        busy    = (busyCnt != 3'd0);
   wire        accept  = busReq & !busy;                         // Strobes while busy dropped

   // Our own status register, physical I/O only
   wire msrCyc  = reqIo & reqPhys & (reqDev == 4'(memDev)) &
                  (reqIoAddr == 18'(addrMsr)) & (reqRead | reqWrite);
   wire memCyc  = !reqIo & (reqRead | reqWrTest | reqWrite);
   wire inRange = ((reqMemAddr >> ramAddrWidth) == '0);          // Below 2**ramAddrWidth

   //////////////////////////////
   // Control pulses
   //////////////////////////////

   always_ff @(posedge cpuClk)
   begin
      if (rst)
      begin
         busyCnt <= 3'd0;
         memGo   <= 1'b0;
         msrWr   <= 1'b0;
         nxmSet  <= 1'b0;
      end
      else
      begin
         memGo  <= accept & (msrCyc | (memCyc & inRange));
         msrWr  <= accept & msrCyc & reqWrite;
         nxmSet <= accept & memCyc & !inRange;         // No ack for these
         if (accept)
            busyCnt <= 3'd4;                           // Covers phases 1 to 4
         else if (busy)
            busyCnt <= busyCnt - 3'd1;
      end
   end

   // Payload held until the next accepted strobe
   always_ff @(posedge cpuClk)
   begin
      if (accept)
      begin
         isWrite   <= reqWrite;
         isMsr     <= msrCyc;
         ramAddr   <= reqMemAddr[memAddrWidth-ramAddrWidth:memAddrWidth-1];
         dataLatch <= busDataIn;
      end
   end

   // Requester must wait out the access before the next strobe
   reqWhileBusy: assert property (@(posedge cpuClk) disable iff (rst) busReq |-> !busy);

endmodule

/* mem/mem.sv */
// Top level of the KS-10 memory controller.
// Joins the bus decoder, status register, access sequencer and RAM.
// Every request the controller recognizes is acknowledged four
// clocks after the strobe.

`timescale 1ns/1ns

module mem #(
      parameter int ramAddrWidth = 10                           // RAM address bits
   ) (
      input  logic                          cpuClk,             // CPU clock
      input  logic                          rst,                // Sync reset
      input  logic                          busReq,             // Request strobe
      input  logic [0:ks10Pkg::busWidth-1]  busAddrIn,          // Flags and address
      input  logic [0:ks10Pkg::busWidth-1]  busDataIn,          // Write data
      output logic                          busAck,             // Acknowledge
      output logic [0:ks10Pkg::busWidth-1]  busDataOut          // Read data
   );

   import ks10Pkg::*;

   // Decoder outputs
   logic                    memGo;
   logic                    isWrite;
   logic                    isMsr;
   logic                    msrWr;
   logic                    nxmSet;
   logic [ramAddrWidth-1:0] ramAddr;
   logic [0:busWidth-1]     dataLatch;

   // Status and RAM paths
   logic [0:busWidth-1]     regStat;
   logic                    ramWe;
   logic [0:busWidth-1]     ramWrData;
   logic [0:busWidth-1]     ramData;

   //////////////////////////////
   // Blocks
   //////////////////////////////

   busDecode #(
      .ramAddrWidth (ramAddrWidth)
   ) uDecode (
      .cpuClk    (cpuClk),
      .rst       (rst),
      .busReq    (busReq),
      .busAddrIn (busAddrIn),
      .busDataIn (busDataIn),
      .memGo     (memGo),
      .isWrite   (isWrite),
      .isMsr     (isMsr),
      .msrWr     (msrWr),
      .nxmSet    (nxmSet),
      .ramAddr   (ramAddr),
      .dataLatch (dataLatch)
   );

   memStat uStat (
      .cpuClk  (cpuClk),
      .rst     (rst),
      .msrWr   (msrWr),
      .nxmSet  (nxmSet),
      .dataIn  (dataLatch),
      .regStat (regStat)
   );

   memSeq uSeq (
      .cpuClk     (cpuClk),
      .rst        (rst),
      .memGo      (memGo),
      .isWrite    (isWrite),
      .isMsr      (isMsr),
      .dataLatch  (dataLatch),
      .regStat    (regStat),
      .ramData    (ramData),
      .ramWe      (ramWe),
      .ramWrData  (ramWrData),
      .busAck     (busAck),
      .busDataOut (busDataOut)
   );

   ssramArray #(
      .ramAddrWidth (ramAddrWidth)
   ) uRam (
      .cpuClk    (cpuClk),
      .ramWe     (ramWe),
      .ramAddr   (ramAddr),
      .ramWrData (ramWrData),
      .ramData   (ramData)
   );

endmodule

/* mem/memSeq.sv */
// Four-phase access sequencer.
// Phase 1 is the start pulse itself, phases 2 to 4 follow on
// successive clocks. Write strobe in phase 2, read data captured
// in phase 3, acknowledge with the data word in phase 4.

`timescale 1ns/1ns

module memSeq (
      input  logic                          cpuClk,       // CPU clock
      input  logic                          rst,          // Sync reset
      input  logic                          memGo,        // Start access
      input  logic                          isWrite,      // Write cycle
      input  logic                          isMsr,        // Status register cycle
      input  logic [0:ks10Pkg::busWidth-1]  dataLatch,    // Latched write data
      input  logic [0:ks10Pkg::busWidth-1]  regStat,      // Status register
      input  logic [0:ks10Pkg::busWidth-1]  ramData,      // RAM read port
      output logic                          ramWe,        // RAM write enable
      output logic [0:ks10Pkg::busWidth-1]  ramWrData,    // RAM write data
      output logic                          busAck,       // Acknowledge pulse
      output logic [0:ks10Pkg::busWidth-1]  busDataOut    // Data to requester
   );

   import ks10Pkg::*;

   logic [2:4]          phsReg;                           // Registered phases
   logic [1:4]          clkPhs;                           // Full phase ring
   logic [0:busWidth-1] readReg;                          // Captured RAM word

   //////////////////////////////
   // Phase ring
   //////////////////////////////

   assign clkPhs = {memGo, phsReg};                       // Phase 1 is the go pulse

   always_ff @(posedge cpuClk)
   begin
      if (rst)
         phsReg <= '0;
      else
         phsReg <= clkPhs[1:3];                           // Shift one phase per clock
   end

   //////////////////////////////
   // RAM side
   //////////////////////////////

   // Status register cycles never touch the array
   assign ramWe     = clkPhs[2] & isWrite & !isMsr;
   assign ramWrData = dataLatch;

   // Array read port lags the address by one clock
   always_ff @(posedge cpuClk)
   begin
      if (clkPhs[3])
         readReg <= ramData;
   end

   //////////////////////////////
   // Bus side
   //////////////////////////////

   assign busAck = clkPhs[4];

   always_comb
   begin
      if (isMsr && !isWrite)
         busDataOut = regStat;                            // MSR read
      else if (isWrite)
         busDataOut = dataLatch;                          // Writes echo their data
      else
         busDataOut = readReg;                            // Read and write-test
   end

   // Catches a start pulse landing inside a running access
   phsOneHot: assert property (@(posedge cpuClk) disable iff (rst) $onehot0(clkPhs));

endmodule

/* mem/memStat.sv */
// Memory status register (MSR).
// Keeps the 8-bit control field and the sticky nonexistent-memory flag.
// All other bits read back as zero.

`timescale 1ns/1ns

module memStat (
      input  logic                          cpuClk,     // CPU clock
      input  logic                          rst,        // Sync reset
      input  logic                          msrWr,      // Register write pulse
      input  logic                          nxmSet,     // Nonexistent memory seen
      input  logic [0:ks10Pkg::busWidth-1]  dataIn,     // Write data
      output logic [0:ks10Pkg::busWidth-1]  regStat     // Register contents
   );

   import ks10Pkg::*;

   logic [msrCtlLo:msrCtlHi] ctlField;                  // Stored control bits
   logic                     nxmFlag;                   // Sticky NXM

   //////////////////////////////
   // Register update
   //////////////////////////////

   always_ff @(posedge cpuClk)
   begin
      if (rst)
      begin
         ctlField <= '0;
         nxmFlag  <= 1'b0;
      end
      else
      begin
         if (msrWr)
            ctlField <= dataIn[msrCtlLo:msrCtlHi];

         // Set beats a write-one-to-clear in the same cycle
         if (nxmSet)
            nxmFlag <= 1'b1;
         else if (msrWr && dataIn[msrNxm])
            nxmFlag <= 1'b0;
      end
   end

   // Read view
   always_comb
   begin
      regStat                    = '0;
      regStat[msrNxm]            = nxmFlag;
      regStat[msrCtlLo:msrCtlHi] = ctlField;
   end

endmodule

/* mem/ssramArray.sv */
// On-chip synchronous word RAM standing in for the SSRAM.
// Single port, write when ramWe is high, and the addressed word is
// registered onto ramData every clock. Read returns the old word
// on the clock of a write to the same address.

`timescale 1ns/1ns

module ssramArray #(
      parameter int ramAddrWidth = 10                           // Address bits
   ) (
      input  logic                          cpuClk,             // CPU clock
      input  logic                          ramWe,              // Write enable
      input  logic [ramAddrWidth-1:0]       ramAddr,            // Word address
      input  logic [0:ks10Pkg::busWidth-1]  ramWrData,          // Write data
      output logic [0:ks10Pkg::busWidth-1]  ramData             // Registered read
   );

   import ks10Pkg::*;

   localparam int ramDepth = 2 ** ramAddrWidth;

   logic [0:busWidth-1] ramArray [0:ramDepth-1];                // Word storage

   //////////////////////////////
   // Array port
   //////////////////////////////

   always_ff @(posedge cpuClk)
   begin
      if (ramWe)
         ramArray[ramAddr] <= ramWrData;
      ramData <= ramArray[ramAddr];                             // Read before write
   end

   // Write data comes from the latched bus word
   wrDataKnown: assert property (@(posedge cpuClk) ramWe |-> !$isunknown(ramWrData));

endmodule

/* run.sh */
#!/bin/sh
# Build the memory controller testbench with Verilator and run it.
# Exits non-zero when the build or the run fails, or the log shows a failure.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module memTb -f filelist.f -o memSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/memSim > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
   echo "Simulation exited with status $runStatus"
   exit 1
fi

if grep -q "TB FAILED" sim.log; then
   exit 1
fi
exit 0

/* tb/memTb.sv */
// Testbench for the KS-10 memory controller top level.
// Issues memory, status register, nonexistent-memory and foreign I/O
// requests, keeps its own shadow of RAM and MSR contents, and lets
// concurrent assertions check acknowledge timing and returned data.

`timescale 1ns/1ns

module memTb;

   import ks10Pkg::*;

   localparam int nWr      = 16;                               // Random writes read back later
   localparam int nWt      = 4;                                // Write-test cycles
   localparam int nChk     = 4;                                // Re-reads after foreign I/O
   localparam int reqTotal = 2 * nWr + nWt + nChk + 11;        // 11 fixed MSR, NXM and I/O requests

   logic                cpuClk = 1'b0;
   logic                rst;
   logic                busReq;
   logic [0:busWidth-1] busAddrIn;
   logic [0:busWidth-1] busDataIn;
   logic                busAck;
   logic [0:busWidth-1] busDataOut;

   // Expected state driven with the strobe
   logic                reqKnown;                              // Strobe should be acked
   logic [0:busWidth-1] expData;                               // Word due with the ack
   logic [0:busWidth-1] expMsr = '0;                           // MSR model
   logic [0:busWidth-1] shadow [0:1023];                       // RAM model
   logic [9:0]          addrList [$];
   logic [9:0]          readOrder [$];
   int                  errCnt = 0;

   mem #(
      .ramAddrWidth (10)
   ) u_mem (
      .cpuClk     (cpuClk),
      .rst        (rst),
      .busReq     (busReq),
      .busAddrIn  (busAddrIn),
      .busDataIn  (busDataIn),
      .busAck     (busAck),
      .busDataOut (busDataOut)
   );

   always #4 cpuClk = ~cpuClk;                                 // 8 ns period

   //////////////////////////////
   // Checks
   //////////////////////////////

   ackInReset: assert property (@(posedge cpuClk) rst |-> !busAck)
      else
      begin
         errCnt++;
         $display("Error: %0t ns busAck high during reset", $time);
      end

   // Ack exactly four cycles after every recognized strobe
   ackDue: assert property (@(posedge cpuClk) disable iff (rst)
         $past(reqKnown, 4) |-> busAck)
      else
      begin
         errCnt++;
         $display("Error: %0t ns busAck missing four cycles after a recognized request",
                  $time);
      end

   // Never an ack without a recognized strobe four cycles back
   ackStray: assert property (@(posedge cpuClk) disable iff (rst)
         !$past(reqKnown, 4) |-> !busAck)
      else
      begin
         errCnt++;
         $display("Error: %0t ns busAck without a recognized request four cycles earlier",
                  $time);
      end

   ackData: assert property (@(posedge cpuClk) disable iff (rst)
         busAck |-> (busDataOut == expData))
      else
      begin
         errCnt++;
         $display("Error: %0t ns busDataOut %o, expected %o", $time, busDataOut, expData);
      end

   //////////////////////////////
   // Helpers
   //////////////////////////////

   function automatic logic [0:busWidth-1] memWord(input logic rd, input logic wt,
                                                   input logic wr, input logic [19:0] addr);
      logic [0:busWidth-1] w;
      w                        = '0;
      w[flagRead]              = rd;
      w[flagWrTest]            = wt;
      w[flagWrite]             = wr;
      w[memAddrLo:busWidth-1]  = addr;                         // 20-bit memory address
      return w;
   endfunction

   function automatic logic [0:busWidth-1] ioWord(input logic rd, input logic wr,
                                                  input logic [3:0] dev,
                                                  input logic [17:0] ioAddr);
      logic [0:busWidth-1] w;
      w                       = '0;
      w[flagRead]             = rd;
      w[flagWrite]            = wr;
      w[flagPhys]             = 1'b1;
      w[flagIo]               = 1'b1;
      w[devLo:devHi]          = dev;
      w[ioAddrLo:busWidth-1]  = ioAddr;
      return w;
   endfunction

   function automatic logic [0:busWidth-1] randWord();
      logic [63:0] r;
      r = {$urandom, $urandom};
      return r[35:0];
   endfunction

   // One-cycle strobe followed by six idle cycles
   // Starts and ends 1 ns past an edge
   task automatic sendReq(input logic [0:busWidth-1] addrWord,
                          input logic [0:busWidth-1] dataWord,
                          input logic known, input logic [0:busWidth-1] expWord);
      busReq    = 1'b1;
      busAddrIn = addrWord;
      busDataIn = dataWord;
      reqKnown  = known;
      expData   = expWord;
      @(posedge cpuClk);
      #1;
      busReq    = 1'b0;
      reqKnown  = 1'b0;
      busAddrIn = '0;
      busDataIn = '0;
      repeat (6) @(posedge cpuClk);
      #1;
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   initial
   begin
      int unsigned         r;
      int                  j;
      logic [9:0]          a;
      logic [9:0]          tmp;
      logic [0:busWidth-1] d;
      r         = $urandom(8977);                              // Seed once
      rst       = 1'b1;
      busReq    = 1'b0;
      busAddrIn = '0;
      busDataIn = '0;
      reqKnown  = 1'b0;
      expData   = '0;
      repeat (8) @(posedge cpuClk);
      #1;
      rst = 1'b0;

      // Random writes echo their data
      for (int i = 0; i < nWr; i++)
      begin
         r = $urandom;
         a = r[9:0];
         d = randWord();
         addrList.push_back(a);
         shadow[a] = d;
         sendReq(memWord(1'b0, 1'b0, 1'b1, {10'd0, a}), d, 1'b1, d);
      end

      // Read back in shuffled order
      readOrder = addrList;
      for (int i = nWr - 1; i > 0; i--)
      begin
         r            = $urandom;
         j            = int'(r % (i + 1));
         tmp          = readOrder[i];
         readOrder[i] = readOrder[j];
         readOrder[j] = tmp;
      end
      foreach (readOrder[i])
         sendReq(memWord(1'b1, 1'b0, 1'b0, {10'd0, readOrder[i]}), '0, 1'b1,
                 shadow[readOrder[i]]);

      for (int i = 0; i < nWt; i++)                            // Write-test acts as a read
         sendReq(memWord(1'b0, 1'b1, 1'b0, {10'd0, addrList[i]}), '0, 1'b1,
                 shadow[addrList[i]]);

      // MSR write then read
      d                          = randWord();
      d[msrNxm]                  = 1'b0;
      expMsr[msrCtlLo:msrCtlHi]  = d[msrCtlLo:msrCtlHi];
      sendReq(ioWord(1'b0, 1'b1, 4'd0, 18'(addrMsr)), d, 1'b1, d);
      sendReq(ioWord(1'b1, 1'b0, 4'd0, 18'(addrMsr)), '0, 1'b1, expMsr);

      // Nonexistent memory aliasing a written word in the low bits
      expMsr[msrNxm] = 1'b1;
      sendReq(memWord(1'b0, 1'b0, 1'b1, {10'd1, addrList[1]}), randWord(), 1'b0, '0);
      sendReq(memWord(1'b1, 1'b0, 1'b0, {10'd512, addrList[2]}), '0, 1'b0, '0);
      sendReq(ioWord(1'b1, 1'b0, 4'd0, 18'(addrMsr)), '0, 1'b1, expMsr);

      // Write one to clear NXM
      d                          = randWord();
      d[msrNxm]                  = 1'b1;
      expMsr[msrCtlLo:msrCtlHi]  = d[msrCtlLo:msrCtlHi];
      expMsr[msrNxm]             = 1'b0;
      sendReq(ioWord(1'b0, 1'b1, 4'd0, 18'(addrMsr)), d, 1'b1, d);
      sendReq(ioWord(1'b1, 1'b0, 4'd0, 18'(addrMsr)), '0, 1'b1, expMsr);

      // Foreign I/O gets no ack and has no side effects
      sendReq(ioWord(1'b0, 1'b1, 4'd3, 18'(addrMsr)), randWord(), 1'b0, '0);
      sendReq(ioWord(1'b0, 1'b1, 4'd0, {8'd0, addrList[0]}), randWord(), 1'b0, '0);
      sendReq(ioWord(1'b1, 1'b0, 4'd5, 18'(addrMsr)), '0, 1'b0, '0);
      sendReq(ioWord(1'b1, 1'b0, 4'd0, 18'(addrMsr)), '0, 1'b1, expMsr);
      for (int i = 0; i < nChk; i++)
         sendReq(memWord(1'b1, 1'b0, 1'b0, {10'd0, addrList[i]}), '0, 1'b1,
                 shadow[addrList[i]]);

      repeat (4) @(posedge cpuClk);
      $display("Run complete, %0d errors", errCnt);
      if (errCnt == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   // Watchdog sized from the request count
   initial
   begin
      repeat (reqTotal * 10 + 200) @(posedge cpuClk);
      $display("Watchdog fired, the run hung before all requests finished, %0d errors", errCnt);
      $display("TB FAILED");
      $finish;
   end

endmodule
